// ==== source/qspi_pkg.sv ====
// Shared widths, flash opcodes, bring-up steps and request/beat/word structs
// for the quad-SPI XIP read subsystem

package qspi_pkg;

    localparam int addr_w         = 24;
    localparam int burst_len      = 4;   // Bytes per word fetch
    localparam int dummy_clks     = 4;   // High-Z clocks before read data
    localparam int addr_mode_clks = (addr_w + 8) / 4;  // Address and mode byte on four lines
    localparam int cs_cool_cycles = 8;   // Two sclk periods of cs high

    localparam logic [7:0] cmd_wake      = 8'hAB;
    localparam logic [7:0] cmd_wren      = 8'h06;
    localparam logic [7:0] cmd_wrsr      = 8'h01;
    localparam logic [7:0] cmd_wrdi      = 8'h04;
    localparam logic [7:0] cmd_quad_read = 8'hEB;
    localparam logic [7:0] xip_mode_byte = 8'h20;   // Keeps the chip in continuous read
    localparam logic [15:0] wrsr_status  = 16'h0002; // Status 1 clear, QE set in status 2

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [2:0]        len;
    } rd_req_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } rd_beat_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
    } word_req_t;

    typedef struct packed {
        logic [31:0] data;
    } word_rsp_t;

    typedef enum logic [2:0] {
        step_wake, step_wren, step_wrsr, step_wrdi, step_xip, step_done
    } setup_step_t;

endpackage

// ==== source/qspi_flash_ctrl.sv ====
// Quad-SPI flash controller: bring-up sequencer and continuous-mode burst reads
// with sequential continue, shift registers and tristate pin drivers
`timescale 1ns/1ns

module qspi_flash_ctrl
    import qspi_pkg::*;
(
    input  logic     capture_clk,
    input  logic     rst,
    input  rd_req_t  req,
    input  logic     req_valid,
    output logic     req_ready,
    output rd_beat_t beat,
    output logic     beat_valid,
    output logic     setup_done,
    output logic     sclk,
    output logic     cs,
    inout  wire      io0,
    inout  wire      io1,
    inout  wire      io2,
    inout  wire      io3
);

    typedef enum logic [2:0] {
        ph_idle, ph_cool, ph_serial, ph_quad, ph_dummy, ph_data, ph_hold
    } phase_t;

    setup_step_t       step;
    phase_t            phase;
    logic              div;        // Halves capture_clk for sclk
    logic [4:0]        clk_cnt;    // sclk periods left in the phase
    logic [3:0]        cool_cnt;
    logic              pend;       // Accepted request still needs its address phase
    logic [31:0]       sh_out;     // MSB goes out first
    logic [3:0]        hi_nib;
    logic              nib_hi;
    logic [addr_w-1:0] addr_r;
    logic [2:0]        len_r;
    logic [addr_w-1:0] next_addr;  // Where the flash resumes while cs stays low
    logic              running;
    logic              sclk_rise;
    logic              sclk_fall;
    logic              accept;

    assign running    = (phase == ph_serial) || (phase == ph_quad) ||
                        (phase == ph_dummy) || (phase == ph_data);
    assign sclk_rise  = running && div && !sclk;
    assign sclk_fall  = running && div && sclk;
    assign setup_done = (step == step_done);
    assign req_ready  = setup_done && ((phase == ph_idle) || (phase == ph_hold));
    assign accept     = req_valid && req_ready;

    // Commands go out on io0; WP# and HOLD# stay high meanwhile
    assign io0 = (phase == ph_serial) ? sh_out[31] :
                 (phase == ph_quad)   ? sh_out[28] : 1'bz;
    assign io1 = (phase == ph_quad) ? sh_out[29] : 1'bz;
    assign io2 = (phase == ph_quad) ? sh_out[30] : (phase == ph_serial) ? 1'b1 : 1'bz;
    assign io3 = (phase == ph_quad) ? sh_out[31] : (phase == ph_serial) ? 1'b1 : 1'bz;

    always_ff @(posedge capture_clk) begin
        if (rst) begin
            step       <= step_wake;
            phase      <= ph_cool;
            cs         <= 1'b1;
            sclk       <= 1'b0;
            div        <= 1'b0;
            clk_cnt    <= '0;
            cool_cnt   <= 4'(cs_cool_cycles);
            pend       <= 1'b0;
            nib_hi     <= 1'b0;
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= 1'b0;
            div        <= running && !div;
            if (running && div) begin
                sclk <= !sclk;
            end
            if (sclk_rise) begin
                clk_cnt <= clk_cnt - 5'd1;
            end
            if (accept) begin
                addr_r    <= req.addr;
                len_r     <= req.len;
                next_addr <= req.addr + addr_w'(req.len);
            end

            case (phase)
                ph_idle: begin
                    if (!setup_done) begin    // Next bring-up command
                        cs    <= 1'b0;
                        phase <= ph_serial;
                        case (step)
                            step_wake: begin
                                sh_out  <= {cmd_wake, 24'h0};
                                clk_cnt <= 5'd8;
                            end
                            step_wren: begin
                                sh_out  <= {cmd_wren, 24'h0};
                                clk_cnt <= 5'd8;
                            end
                            step_wrsr: begin
                                sh_out  <= {cmd_wrsr, wrsr_status, 8'h0};
                                clk_cnt <= 5'd24;
                            end
                            step_wrdi: begin
                                sh_out  <= {cmd_wrdi, 24'h0};
                                clk_cnt <= 5'd8;
                            end
                            default: begin
                                sh_out  <= {cmd_quad_read, 24'h0};
                                clk_cnt <= 5'd8;
                            end
                        endcase
                    end else if (accept) begin
                        phase <= ph_cool;    // cs already high long enough
                        pend  <= 1'b1;
                    end
                end
                ph_cool: begin
                    if (cool_cnt != 4'd0) begin
                        cool_cnt <= cool_cnt - 4'd1;
                    end else if (pend) begin
                        cs      <= 1'b0;
                        phase   <= ph_quad;
                        sh_out  <= {addr_r, xip_mode_byte};
                        clk_cnt <= 5'(addr_mode_clks);
                        pend    <= 1'b0;
                    end else begin
                        phase <= ph_idle;
                    end
                end
                ph_serial: begin
                    if (sclk_fall && clk_cnt == 5'd0) begin
                        if (step == step_xip) begin
                            // Opcode done, address zero and mode byte follow on four lines
                            phase   <= ph_quad;
                            sh_out  <= {{addr_w{1'b0}}, xip_mode_byte};
                            clk_cnt <= 5'(addr_mode_clks);
                        end else begin
                            cs       <= 1'b1;
                            phase    <= ph_cool;
                            cool_cnt <= 4'(cs_cool_cycles);
                            step     <= setup_step_t'(step + 1);
                        end
                    end else if (sclk_fall) begin
                        sh_out <= {sh_out[30:0], 1'b0};
                    end
                end
                ph_quad: begin
                    if (sclk_fall && clk_cnt == 5'd0) begin
                        phase   <= ph_dummy;
                        clk_cnt <= 5'(dummy_clks);
                    end else if (sclk_fall) begin
                        sh_out <= {sh_out[27:0], 4'h0};
                    end
                end
                ph_dummy: begin
                    if (sclk_fall && clk_cnt == 5'd0) begin
                        if (!setup_done) begin    // End of bring-up, no data wanted
                            cs       <= 1'b1;
                            phase    <= ph_cool;
                            cool_cnt <= 4'(cs_cool_cycles);
                            step     <= step_done;
                        end else begin
                            phase   <= ph_data;
                            clk_cnt <= {1'b0, len_r, 1'b0};
                            nib_hi  <= 1'b0;
                        end
                    end
                end
                ph_data: begin
                    if (sclk_rise) begin
                        if (nib_hi) begin
                            beat.data  <= {hi_nib, io3, io2, io1, io0};
                            beat.last  <= (clk_cnt == 5'd1);
                            beat_valid <= 1'b1;
                        end else begin
                            hi_nib <= {io3, io2, io1, io0};    // High nibble first
                        end
                        nib_hi <= !nib_hi;
                    end
                    if (sclk_fall && clk_cnt == 5'd0) begin
                        phase <= ph_hold;    // sclk parks low, cs stays low
                    end
                end
                ph_hold: begin
                    if (accept && req.addr == next_addr) begin
                        phase   <= ph_data;
                        clk_cnt <= {1'b0, req.len, 1'b0};
                        nib_hi  <= 1'b0;
                    end else if (accept) begin
                        cs       <= 1'b1;
                        phase    <= ph_cool;
                        cool_cnt <= 4'(cs_cool_cycles);
                        pend     <= 1'b1;
                    end
                end
                default: phase <= ph_idle;
            endcase
        end
    end

endmodule

// ==== source/flash_read_arbiter.sv ====
// Round-robin arbiter for two burst requesters sharing one flash controller
`timescale 1ns/1ns

module flash_read_arbiter
    import qspi_pkg::*;
(
    input  logic     capture_clk,
    input  logic     rst,
    input  rd_req_t  req0,
    input  logic     req0_valid,
    output logic     req0_ready,
    input  rd_req_t  req1,
    input  logic     req1_valid,
    output logic     req1_ready,
    output rd_req_t  req,
    output logic     req_valid,
    input  logic     req_ready,
    input  rd_beat_t beat,
    input  logic     beat_valid,
    output rd_beat_t beat0,
    output logic     beat0_valid,
    output rd_beat_t beat1,
    output logic     beat1_valid
);

    logic busy;         // A burst is in flight
    logic owner;        // Port that owns the burst
    logic last_served;
    logic pick;

    // With both requesting, the port not served last wins
    always_comb begin
        if (req0_valid && req1_valid) begin
            pick = !last_served;
        end else begin
            pick = req1_valid;
        end
    end

    assign req        = pick ? req1 : req0;
    assign req_valid  = !busy && (req0_valid || req1_valid);
    assign req0_ready = !busy && !pick && req_ready;
    assign req1_ready = !busy && pick && req_ready;

    assign beat0       = beat;
    assign beat1       = beat;
    assign beat0_valid = beat_valid && busy && !owner;
    assign beat1_valid = beat_valid && busy && owner;

    always_ff @(posedge capture_clk) begin
        if (rst) begin
            busy        <= 1'b0;
            owner       <= 1'b0;
            last_served <= 1'b1;
        end else if (req_valid && req_ready) begin
            busy        <= 1'b1;
            owner       <= pick;
            last_served <= pick;
        end else if (beat_valid && beat.last) begin
            busy <= 1'b0;    // Grant released after the last byte
        end
    end

endmodule

// ==== source/word_fetch_port.sv ====
// Word fetch front end: one word request becomes a four-byte flash burst,
// returned bytes are assembled little-endian
`timescale 1ns/1ns

module word_fetch_port
    import qspi_pkg::*;
(
    input  logic      capture_clk,
    input  logic      rst,
    input  logic      setup_done,
    input  word_req_t word_req,
    input  logic      word_req_valid,
    output logic      word_req_ready,
    output word_rsp_t word_rsp,
    output logic      word_rsp_valid,
    output rd_req_t   rd_req,
    output logic      rd_req_valid,
    input  logic      rd_req_ready,
    input  rd_beat_t  rd_beat,
    input  logic      rd_beat_valid
);

    logic              busy;
    logic [addr_w-1:0] addr_r;

    assign word_req_ready = setup_done && !busy;
    assign rd_req.addr    = addr_r;
    assign rd_req.len     = 3'(burst_len);

    always_ff @(posedge capture_clk) begin
        if (rst) begin
            busy           <= 1'b0;
            rd_req_valid   <= 1'b0;
            word_rsp_valid <= 1'b0;
        end else begin
            word_rsp_valid <= 1'b0;
            if (word_req_valid && word_req_ready) begin
                busy         <= 1'b1;
                rd_req_valid <= 1'b1;
                addr_r       <= word_req.addr;
            end else if (rd_req_valid && rd_req_ready) begin
                rd_req_valid <= 1'b0;    // Burst granted, wait for bytes
            end
            if (rd_beat_valid) begin
                // Bytes enter at the top, the first one ends in bits 7:0
                word_rsp.data <= {rd_beat.data, word_rsp.data[31:8]};
                if (rd_beat.last) begin
                    busy           <= 1'b0;
                    word_rsp_valid <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== source/qspi_read_top.sv ====
// Top level: two word fetch ports, round-robin arbiter and quad-SPI controller
`timescale 1ns/1ns

module qspi_read_top
    import qspi_pkg::*;
(
    input  logic      capture_clk,
    input  logic      rst,
    input  word_req_t word_req0,
    input  logic      word_req0_valid,
    output logic      word_req0_ready,
    output word_rsp_t word_rsp0,
    output logic      word_rsp0_valid,
    input  word_req_t word_req1,
    input  logic      word_req1_valid,
    output logic      word_req1_ready,
    output word_rsp_t word_rsp1,
    output logic      word_rsp1_valid,
    output logic      setup_done,
    output logic      sclk,
    output logic      cs,
    inout  wire       io0,
    inout  wire       io1,
    inout  wire       io2,
    inout  wire       io3
);

    rd_req_t  rd_req0, rd_req1, ctrl_req;
    logic     rd_req0_valid, rd_req0_ready, rd_req1_valid, rd_req1_ready;
    logic     ctrl_req_valid, ctrl_req_ready;
    rd_beat_t ctrl_beat, rd_beat0, rd_beat1;
    logic     ctrl_beat_valid, rd_beat0_valid, rd_beat1_valid;

    word_fetch_port u_port0 (
        .capture_clk, .rst, .setup_done,
        .word_req(word_req0), .word_req_valid(word_req0_valid), .word_req_ready(word_req0_ready),
        .word_rsp(word_rsp0), .word_rsp_valid(word_rsp0_valid),
        .rd_req(rd_req0), .rd_req_valid(rd_req0_valid), .rd_req_ready(rd_req0_ready),
        .rd_beat(rd_beat0), .rd_beat_valid(rd_beat0_valid)
    );

    word_fetch_port u_port1 (
        .capture_clk, .rst, .setup_done,
        .word_req(word_req1), .word_req_valid(word_req1_valid), .word_req_ready(word_req1_ready),
        .word_rsp(word_rsp1), .word_rsp_valid(word_rsp1_valid),
        .rd_req(rd_req1), .rd_req_valid(rd_req1_valid), .rd_req_ready(rd_req1_ready),
        .rd_beat(rd_beat1), .rd_beat_valid(rd_beat1_valid)
    );

    flash_read_arbiter u_arbiter (
        .capture_clk, .rst,
        .req0(rd_req0), .req0_valid(rd_req0_valid), .req0_ready(rd_req0_ready),
        .req1(rd_req1), .req1_valid(rd_req1_valid), .req1_ready(rd_req1_ready),
        .req(ctrl_req), .req_valid(ctrl_req_valid), .req_ready(ctrl_req_ready),
        .beat(ctrl_beat), .beat_valid(ctrl_beat_valid),
        .beat0(rd_beat0), .beat0_valid(rd_beat0_valid),
        .beat1(rd_beat1), .beat1_valid(rd_beat1_valid)
    );

    qspi_flash_ctrl u_ctrl (
        .capture_clk, .rst,
        .req(ctrl_req), .req_valid(ctrl_req_valid), .req_ready(ctrl_req_ready),
        .beat(ctrl_beat), .beat_valid(ctrl_beat_valid),
        .setup_done, .sclk, .cs, .io0, .io1, .io2, .io3
    );

endmodule

// ==== bench/qspi_flash_model.sv ====
// Behavioral quad-SPI NOR flash: bring-up command decode, continuous quad reads
// and content derived from the byte address
`timescale 1ns/1ns

module qspi_flash_model
    import qspi_pkg::*;
(
    input  logic rst,
    input  logic sclk,
    input  logic cs,
    inout  wire  io0,
    inout  wire  io1,
    inout  wire  io2,
    inout  wire  io3,
    output logic setup_ok    // Bring-up commands seen in order
);

    logic              xip      = 1'b0;    // Continuous read armed for the next select
    logic              wel      = 1'b0;
    logic              qe       = 1'b0;
    logic              xip_sess = 1'b0;    // This select began in continuous mode
    logic              quad_rd  = 1'b0;
    logic              drive    = 1'b0;
    logic              nib_lo   = 1'b0;
    logic [31:0]       sh_ser   = '0;
    logic [31:0]       sh_quad  = '0;
    logic [7:0]        mode_r   = '0;
    logic [addr_w-1:0] rd_addr  = '0;
    logic [3:0]        dout     = '0;
    int                rises    = 0;
    int                base     = 0;       // Rising edges before the quad address
    int                seq_pos  = 0;
    logic              seq_err  = 1'b0;

    assign setup_ok = (seq_pos == 5) && !seq_err;
    assign {io3, io2, io1, io0} = (drive && !cs) ? dout : 4'bzzzz;

    function automatic logic [7:0] content_at(input logic [addr_w-1:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5A;
    endfunction

    // Expected order: wake, wren, wrsr, wrdi, quad read
    task automatic log_command(input int idx);
        if (idx == seq_pos) begin
            seq_pos++;
        end else begin
            seq_err = 1'b1;
        end
    endtask

    // Bench reset puts the chip back in its power-up state
    always @(posedge rst) begin
        xip     = 1'b0;
        wel     = 1'b0;
        qe      = 1'b0;
        drive   = 1'b0;
        quad_rd = 1'b0;
        seq_pos = 0;
        seq_err = 1'b0;
    end

    always @(negedge cs) begin
        rises    = 0;
        drive    = 1'b0;
        nib_lo   = 1'b0;
        xip_sess = xip;
        quad_rd  = xip;    // Continuous mode starts straight at the address
        base     = 0;
    end

    always @(posedge sclk) begin
        if (!cs && !rst) begin
            rises++;
            if (!xip_sess) begin
                sh_ser = {sh_ser[30:0], io0};
            end
            if (!xip_sess && rises == 8 && sh_ser[7:0] == cmd_quad_read && qe) begin
                quad_rd = 1'b1;
                base    = 8;
            end else if (quad_rd && rises > base && rises <= base + 8) begin
                sh_quad = {sh_quad[27:0], io3, io2, io1, io0};
                if (rises == base + 8) begin
                    rd_addr = sh_quad[31:8];
                    mode_r  = sh_quad[7:0];
                end
            end
        end
    end

    // Data changes on the falling edge, high nibble first
    always @(negedge sclk) begin : drive_nibble
        logic [7:0] b;
        if (!cs && quad_rd && rises >= base + 8 + dummy_clks) begin
            b = content_at(rd_addr);
            if (nib_lo) begin
                dout = b[3:0];
                rd_addr++;
            end else begin
                dout = b[7:4];
            end
            nib_lo = !nib_lo;
            drive  = 1'b1;
        end
    end

    always @(posedge cs) begin
        drive = 1'b0;
        if (!rst && !xip_sess) begin
            if (rises == 8) begin
                case (sh_ser[7:0])
                    cmd_wake: log_command(0);
                    cmd_wren: begin
                        wel = 1'b1;
                        log_command(1);
                    end
                    cmd_wrdi: begin
                        wel = 1'b0;
                        log_command(3);
                    end
                    default: ;
                endcase
            end else if (rises == 24 && sh_ser[23:16] == cmd_wrsr && wel) begin
                qe  = sh_ser[1];    // QE sits in bit 1 of status register 2
                wel = 1'b0;
                if (qe) begin
                    log_command(2);
                end
            end
        end
        if (!rst && quad_rd && rises >= base + 8) begin
            xip = (mode_r == xip_mode_byte);
            if (!xip_sess && xip) begin
                log_command(4);
            end
        end
    end

endmodule

// ==== bench/tb_qspi_read.sv ====
// Testbench for the quad-SPI read subsystem: two word ports against a flash model,
// reference function, per-port response checking and timeout
`timescale 1ns/1ns

module tb_qspi_read
    import qspi_pkg::*;
();

    localparam int n_single    = 16;
    localparam int n_seq       = 12;
    localparam int n_rounds    = 16;
    localparam int n_after     = 6;
    localparam int n_reqs      = n_single + n_seq + 2 * n_rounds + n_after + 1;
    localparam int cycle_limit = 400 * n_reqs + 2000 * 2;    // Two bring-ups

    logic      capture_clk;
    logic      rst;
    word_req_t word_req0, word_req1;
    logic      word_req0_valid, word_req1_valid;
    logic      word_req0_ready, word_req1_ready;
    word_rsp_t word_rsp0, word_rsp1;
    logic      word_rsp0_valid, word_rsp1_valid;
    logic      setup_done, sclk, cs, setup_ok;
    wire       io0, io1, io2, io3;

    int                errors   = 0;
    int                cycles   = 0;
    int                rsp_cnt0 = 0;
    int                rsp_cnt1 = 0;
    int                cs_rises = 0;
    int                start0   = 0;
    int                start1   = 0;
    int                max_lead = 0;    // Largest lead of one port while both request
    string             test_name = "none";
    logic [addr_w-1:0] exp_addr0[$];
    logic [addr_w-1:0] exp_addr1[$];

    qspi_read_top i_dut (
        .capture_clk, .rst,
        .word_req0, .word_req0_valid, .word_req0_ready, .word_rsp0, .word_rsp0_valid,
        .word_req1, .word_req1_valid, .word_req1_ready, .word_rsp1, .word_rsp1_valid,
        .setup_done, .sclk, .cs, .io0, .io1, .io2, .io3
    );

    qspi_flash_model u_flash (.rst, .sclk, .cs, .io0, .io1, .io2, .io3, .setup_ok);

    initial begin
        capture_clk = 1'b0;
        forever #2 capture_clk = ~capture_clk;
    end

    function automatic logic [7:0] flash_byte(input logic [addr_w-1:0] addr);
        return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ 8'h5A;
    endfunction

    // Four bytes from addr upward, first byte in bits 7:0
    function automatic word_rsp_t expected_word(input logic [addr_w-1:0] addr);
        word_rsp_t w;
        for (int i = 0; i < 4; i++) begin
            w.data[8*i +: 8] = flash_byte(addr + addr_w'(i));
        end
        return w;
    endfunction

    task automatic check_word(input string name, input word_rsp_t exp, input word_rsp_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp.data, act.data);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic send_word(input int port, input logic [addr_w-1:0] addr);
        @(posedge capture_clk);
        #1;
        if (port == 0) begin
            word_req0.addr  = addr;
            word_req0_valid = 1'b1;
        end else begin
            word_req1.addr  = addr;
            word_req1_valid = 1'b1;
        end
        while (!(port == 0 ? word_req0_ready : word_req1_ready)) begin
            @(posedge capture_clk);
            #1;
        end
        if (port == 0) begin
            exp_addr0.push_back(addr);
        end else begin
            exp_addr1.push_back(addr);
        end
        @(posedge capture_clk);    // Taken on this edge
        #1;
        if (port == 0) begin
            word_req0_valid = 1'b0;
        end else begin
            word_req1_valid = 1'b0;
        end
    endtask

    task automatic fetch_word(input int port, input logic [addr_w-1:0] addr);
        int target;
        target = (port == 0 ? rsp_cnt0 : rsp_cnt1) + 1;
        send_word(port, addr);
        if (port == 0) begin
            wait (rsp_cnt0 >= target);
        end else begin
            wait (rsp_cnt1 >= target);
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (8) @(posedge capture_clk);
        #1;
        check_flag("reset_setup_done", 1'b0, setup_done);
        check_flag("reset_rsp_valid", 1'b0, word_rsp0_valid | word_rsp1_valid);
        check_flag("reset_req_ready", 1'b0, word_req0_ready | word_req1_ready);
        check_flag("reset_cs_high", 1'b1, cs);
        check_flag("reset_sclk_low", 1'b0, sclk);
        rst = 1'b0;
    endtask

    // Responses are sampled away from the rising edge
    always @(negedge capture_clk) begin : compare_rsp
        logic [addr_w-1:0] a;
        int                lead;
        if (!rst && word_rsp0_valid) begin
            if (exp_addr0.size() == 0) begin
                $display("Port 0 returned a word with no request outstanding");
                errors++;
            end else begin
                a = exp_addr0.pop_front();
                check_word({test_name, "_port0"}, expected_word(a), word_rsp0);
            end
            rsp_cnt0++;
        end
        if (!rst && word_rsp1_valid) begin
            if (exp_addr1.size() == 0) begin
                $display("Port 1 returned a word with no request outstanding");
                errors++;
            end else begin
                a = exp_addr1.pop_front();
                check_word({test_name, "_port1"}, expected_word(a), word_rsp1);
            end
            rsp_cnt1++;
        end
        if (test_name == "both_ports") begin
            lead = (rsp_cnt0 - start0) - (rsp_cnt1 - start1);
            if (lead < 0) begin
                lead = -lead;
            end
            if (lead > max_lead) begin
                max_lead = lead;
            end
        end
    end

    always @(posedge cs) begin
        cs_rises++;
    end

    always @(posedge capture_clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run still busy after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        logic [addr_w-1:0] base;
        logic [addr_w-1:0] addrs0[n_rounds];
        logic [addr_w-1:0] addrs1[n_rounds];
        int                cs_mark;
        void'($urandom(32'h74e4_126c));
        rst             = 1'b1;
        word_req0       = '0;
        word_req1       = '0;
        word_req0_valid = 1'b0;
        word_req1_valid = 1'b0;

        test_name = "bringup";
        apply_reset();
        wait (setup_done === 1'b1);
        @(posedge capture_clk);
        #1;
        check_flag("bringup_sequence", 1'b1, setup_ok);

        test_name = "single_port0";
        for (int i = 0; i < n_single; i++) begin
            fetch_word(0, addr_w'($urandom));
        end

        // After the first word cs must stay low across the run
        test_name = "sequential_port1";
        base = addr_w'($urandom);
        fetch_word(1, base);
        cs_mark = cs_rises;
        for (int i = 1; i < n_seq; i++) begin
            fetch_word(1, base + addr_w'(4 * i));
        end
        check_flag("sequential_cs_held", 1'b1, cs_rises == cs_mark);

        foreach (addrs0[i]) begin
            addrs0[i] = addr_w'($urandom);
            addrs1[i] = addr_w'($urandom);
        end
        start0 = rsp_cnt0;
        start1 = rsp_cnt1;
        test_name = "both_ports";
        fork
            for (int i = 0; i < n_rounds; i++) fetch_word(0, addrs0[i]);
            for (int i = 0; i < n_rounds; i++) fetch_word(1, addrs1[i]);
        join
        // Grants alternate while both ports keep requesting
        check_flag("both_ports_alternate", 1'b1, max_lead <= 1);

        // Reset lands while a read is in flight, its word is dropped
        test_name = "reset_mid_read";
        send_word(0, addr_w'($urandom));
        repeat (12) @(posedge capture_clk);
        #1;
        apply_reset();
        exp_addr0.delete();
        wait (setup_done === 1'b1);
        @(posedge capture_clk);
        #1;
        check_flag("bringup_after_reset", 1'b1, setup_ok);

        test_name = "reads_after_reset";
        for (int i = 0; i < n_after; i++) begin
            fetch_word(i % 2, addr_w'($urandom));
        end

        $display("Run complete: %0d errors, %0d port 0 and %0d port 1 words checked",
                 errors, rsp_cnt0, rsp_cnt1);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
source/qspi_pkg.sv
source/qspi_flash_ctrl.sv
source/flash_read_arbiter.sv
source/word_fetch_port.sv
source/qspi_read_top.sv
bench/qspi_flash_model.sv
bench/tb_qspi_read.sv

// ==== Bender.yml ====
package:
  name: qspi_read

sources:
  - source/qspi_pkg.sv
  - source/qspi_flash_ctrl.sv
  - source/flash_read_arbiter.sv
  - source/word_fetch_port.sv
  - source/qspi_read_top.sv
  - target: test
    files:
      - bench/qspi_flash_model.sv
      - bench/tb_qspi_read.sv
